// ==== processor.f ====
rtl/cpuPkg.sv
rtl/mulIf.sv
rtl/alu.sv
rtl/mulSequencer.sv
rtl/multiplier.sv
rtl/fetchDecode.sv
rtl/executeStage.sv
rtl/hazardUnit.sv
rtl/memWriteback.sv
rtl/processor.sv
verif/processorTb.sv

// ==== Bender.yml ====
package:
  name: processor

dependencies: {}

sources:
  - rtl/cpuPkg.sv
  - rtl/mulIf.sv
  - rtl/alu.sv
  - rtl/mulSequencer.sv
  - rtl/multiplier.sv
  - rtl/fetchDecode.sv
  - rtl/executeStage.sv
  - rtl/hazardUnit.sv
  - rtl/memWriteback.sv
  - rtl/processor.sv
  - target: test
    files:
      - verif/processorTb.sv

// ==== verif/processorTb.sv ====
/*
 * processorTb
 * Random program on the pipelined core with external memories and register
 * file, register writes and stores checked in order against an ISA model
 */
`timescale 1ns/1ps
`default_nettype none

module processorTb;
    import cpuPkg::*;

    localparam int imemWords     = 64;
    localparam int progLen       = 48;     // Followed by nops
    localparam int timeoutCycles = (progLen + 8) * (mulSteps + 4) + 100;

    logic   clock;
    logic   rstN;
    wordT   addressImem, qImem, addressDmem, data, qDmem;
    wordT   dataWriteReg, dataReadRegA, dataReadRegB;
    logic   wren, ctrlWriteEnable;
    regIdxT ctrlWriteReg, ctrlReadRegA, ctrlReadRegB;

    wordT        imem [imemWords];
    wordT        dmem [256];
    wordT        rf [32];
    logic [31:0] lfsr;

    regIdxT expReg[$];      // Expected register writes, in order
    wordT   expVal[$];
    int     expWrTag[$];    // Behavior each entry counts toward
    wordT   expAddr[$];     // Expected stores, in order
    wordT   expData[$];
    int     expStTag[$];
    int     wrSeen, stSeen, cycles, failTotal;
    int     passCnt [1:5];
    int     failCnt [1:5];
    logic   timedOut;

    processor dut (.*);

    // Combinational memories, write-first register file
    assign qImem = (addressImem < imemWords) ? imem[addressImem[5:0]] : nopWord;
    assign qDmem = dmem[addressDmem[7:0]];
    assign dataReadRegA = (ctrlReadRegA == '0) ? '0 :
        (ctrlWriteEnable && ctrlWriteReg == ctrlReadRegA) ? dataWriteReg : rf[ctrlReadRegA];
    assign dataReadRegB = (ctrlReadRegB == '0) ? '0 :
        (ctrlWriteEnable && ctrlWriteReg == ctrlReadRegB) ? dataWriteReg : rf[ctrlReadRegB];

    always @(posedge clock) begin
        if (rstN && ctrlWriteEnable && ctrlWriteReg != '0) rf[ctrlWriteReg] <= dataWriteReg;
        if (rstN && wren) dmem[addressDmem[7:0]] <= data;
    end

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic checkValue(int tag, string name, wordT expected, wordT actual);
        assert (actual === expected) begin
            passCnt[tag] += 1;
        end else begin
            $display("mismatch at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            failCnt[tag] += 1;
        end
    endtask

    task automatic buildProgram();
        logic [2:0]  kind;
        regIdxT      rd, rs, rt;
        aluOpT       fn;
        logic [16:0] off;
        for (int i = 0; i < imemWords; i++) imem[i] = nopWord;
        for (int i = 0; i < progLen; i++) begin
            kind = 3'(randBits(3));
            rd   = regIdxT'(randBits(3));     // r0 to r7
            rs   = regIdxT'(randBits(3));
            rt   = regIdxT'(randBits(3));
            off  = 17'(randBits(2) % 3 + 1);  // Forward 1 to 3
            case (kind)
                3'd0, 3'd1: begin
                    fn      = aluOpT'(randBits(3) % 6);   // add through sra
                    imem[i] = {opAlu, rd, rs, rt, 5'(randBits(5)), fn, 2'b00};
                end
                3'd2:    imem[i] = {opAddi, rd, rs, 17'(randBits(17))};
                3'd3:    imem[i] = {opAlu, rd, rs, rt, 5'd0, aluMul, 2'b00};
                3'd4:    imem[i] = {opLw, rd, rs, 17'(randBits(4))};   // Small offsets
                3'd5:    imem[i] = {opSw, rd, rs, 17'(randBits(4))};
                3'd6:    imem[i] = {(randBits(1) ? opBne : opBlt), rd, rs, off};
                default: imem[i] = {opJ, 27'(i + 1 + off)};
            endcase
        end
    endtask

    // ISA reference, one instruction at a time from zeroed state
    task automatic runModel();
        wordT       regs [32];
        wordT       mem [256];
        wordT       ir, a, b, rdVal, imm, res, ea;
        logic [4:0] sh;
        int         pc, nextPc, age, tag;
        logic       wr;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 256; i++) mem[i] = '0;
        pc  = 0;
        age = 2;
        while (pc < imemWords) begin
            ir     = imem[pc];
            a      = regs[ir[21:17]];          // $rs
            b      = regs[ir[16:12]];          // $rt
            rdVal  = regs[ir[26:22]];
            sh     = ir[11:7];
            imm    = {{15{ir[16]}}, ir[16:0]};
            ea     = a + imm;
            nextPc = pc + 1;
            wr     = 1'b0;
            res    = '0;
            tag    = 1;
            case (ir[31:27])
                opAlu: begin
                    wr = 1'b1;
                    case (ir[6:2])
                        aluAdd:  res = a + b;
                        aluSub:  res = a - b;
                        aluAnd:  res = a & b;
                        aluOr:   res = a | b;
                        aluSll:  res = a << sh;
                        aluSra:  res = $signed(a) >>> sh;
                        default: begin
                            res = a * b;       // Low word only
                            tag = 4;
                        end
                    endcase
                end
                opAddi: begin
                    wr  = 1'b1;
                    res = ea;
                end
                opLw: begin
                    wr  = 1'b1;
                    res = mem[ea[7:0]];
                    tag = 2;
                end
                opSw: begin
                    mem[ea[7:0]] = rdVal;
                    tag = 2;
                end
                opBne: if (rdVal != a) nextPc = pc + 1 + imm;
                opBlt: if ($signed(rdVal) < $signed(a)) nextPc = pc + 1 + imm;
                opJ:   nextPc = ir[26:0];
                default: ;
            endcase
            if (age < 2) tag = 3;              // Just behind a branch or jump
            age = (ir[31:27] inside {opBne, opBlt, opJ}) ? 0 : age + 1;
            if (wr && ir[26:22] != '0) begin
                regs[ir[26:22]] = res;
                expReg.push_back(ir[26:22]);
                expVal.push_back(res);
                expWrTag.push_back(tag);
            end
            if (ir[31:27] == opSw) begin
                expAddr.push_back(ea);
                expData.push_back(rdVal);
                expStTag.push_back(tag);
            end
            pc = nextPc;
        end
    endtask

    // Outputs sampled mid-cycle, well clear of the edges
    always @(negedge clock) begin
        if (rstN && ctrlWriteEnable) begin
            assert (ctrlWriteReg != '0) else begin
                $display("register 0 written at %0t ns", $time);
                failCnt[5] += 1;
            end
            assert (wrSeen < expReg.size()) else begin
                $display("extra register write to r%0d at %0t ns", ctrlWriteReg, $time);
                failCnt[5] += 1;
            end
            if (wrSeen < expReg.size()) begin
                checkValue(expWrTag[wrSeen], "ctrlWriteReg", expReg[wrSeen], ctrlWriteReg);
                checkValue(expWrTag[wrSeen], "dataWriteReg", expVal[wrSeen], dataWriteReg);
            end
            wrSeen++;
        end
        if (rstN && wren) begin
            assert (stSeen < expAddr.size()) else begin
                $display("extra store to %h at %0t ns", addressDmem, $time);
                failCnt[5] += 1;
            end
            if (stSeen < expAddr.size()) begin
                checkValue(expStTag[stSeen], "addressDmem", expAddr[stSeen], addressDmem);
                checkValue(expStTag[stSeen], "data", expData[stSeen], data);
            end
            stSeen++;
        end
    end

    task automatic printReport();
        string names [1:5];
        int    passTotal;
        names[1]  = "dependent ALU and addi chains";
        names[2]  = "loads and stores";
        names[3]  = "branches, jumps and flushes";
        names[4]  = "multiply results";
        names[5]  = "r0 and write/store counts";
        failTotal = 0;
        passTotal = 0;
        for (int t = 1; t <= 5; t++) begin
            $display("behavior %0d, %s: %0d checks ok, %0d bad", t, names[t],
                     passCnt[t], failCnt[t]);
            passTotal += passCnt[t];
            failTotal += failCnt[t];
        end
        $display("total checks ok %0d, bad %0d", passTotal, failTotal);
    endtask

    initial begin
        rstN     = 1'b0;
        lfsr     = 32'hb353;
        wrSeen   = 0;
        stSeen   = 0;
        cycles   = 0;
        timedOut = 1'b0;
        for (int t = 1; t <= 5; t++) begin
            passCnt[t] = 0;
            failCnt[t] = 0;
        end
        for (int i = 0; i < 32; i++) rf[i] = '0;
        for (int i = 0; i < 256; i++) dmem[i] = '0;
        buildProgram();
        runModel();
        repeat (8) @(posedge clock);
        #1 rstN = 1'b1;
        // Done once fetch runs off the end of imem
        while (addressImem < imemWords && cycles < timeoutCycles) begin
            @(negedge clock);
            cycles++;
        end
        if (cycles >= timeoutCycles) begin
            $display("timeout, program still running after %0d cycles", cycles);
            timedOut = 1'b1;
        end else begin
            repeat (10) @(negedge clock);          // Drain and catch stray writes
            checkValue(5, "register write count", expReg.size(), wrSeen);
            checkValue(5, "store count", expAddr.size(), stSeen);
        end
        printReport();
        if (!timedOut && failTotal == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/processor.sv ====
/*
 * processor
 * Five-stage in-order pipelined core. Instruction memory, data memory and
 * the register file live outside and answer in the same cycle
 */
`timescale 1ns/1ps
`default_nettype none

module processor (
    input  logic           clock,
    input  logic           rstN,
    output cpuPkg::wordT   addressImem,
    input  cpuPkg::wordT   qImem,
    output cpuPkg::wordT   addressDmem,
    output cpuPkg::wordT   data,
    output logic           wren,
    input  cpuPkg::wordT   qDmem,
    output logic           ctrlWriteEnable,
    output cpuPkg::regIdxT ctrlWriteReg,
    output cpuPkg::regIdxT ctrlReadRegA,
    output cpuPkg::regIdxT ctrlReadRegB,
    output cpuPkg::wordT   dataWriteReg,
    input  cpuPkg::wordT   dataReadRegA,
    input  cpuPkg::wordT   dataReadRegB
);
    import cpuPkg::*;

    wordT   fdIr;
    wordT   fdPc;
    wordT   dxIr;
    wordT   xmIr;
    wordT   xmO;
    wordT   xmB;
    wordT   mwIr;
    wordT   wbValue;           // Writeback data, also a bypass source
    wordT   branchTarget;
    logic   branchTaken;
    logic   mulPending;
    logic   stallF;
    logic   stallD;
    logic   stallX;
    logic   stallM;
    logic   bubbleX;
    logic   fwdStore;
    fwdSelT fwdA;
    fwdSelT fwdB;

    mulIf mif ();

    fetchDecode uFetch (
        .clock, .rstN, .qImem, .stallF, .stallD, .branchTaken, .branchTarget,
        .addressImem, .fdIr, .fdPc, .ctrlReadRegA, .ctrlReadRegB
    );

    executeStage uExecute (
        .clock, .rstN, .fdIr, .fdPc, .dataReadRegA, .dataReadRegB,
        .stallX, .stallM, .bubbleX, .fwdA, .fwdB, .wbValue,
        .dxIr, .branchTaken, .branchTarget, .xmIr, .xmO, .xmB, .mulPending,
        .mif(mif.requester)
    );

    multiplier uMul (.clock, .rstN, .mif(mif.unit));

    hazardUnit uHazard (
        .fdIr, .dxIr, .xmIr, .mwIr, .mif(mif.monitor), .mulPending,
        .stallF, .stallD, .stallX, .stallM, .bubbleX, .fwdA, .fwdB, .fwdStore
    );

    memWriteback uMemWb (
        .clock, .rstN, .xmIr, .xmO, .xmB, .qDmem, .fwdStore,
        .addressDmem, .data, .wren, .mwIr,
        .ctrlWriteEnable, .ctrlWriteReg, .dataWriteReg, .wbValue
    );

endmodule

`default_nettype wire

// ==== rtl/memWriteback.sv ====
/*
 * memWriteback
 * Data memory access, the M/W latch and the register file write port
 */
`timescale 1ns/1ps
`default_nettype none

module memWriteback (
    input  logic           clock,
    input  logic           rstN,
    input  cpuPkg::wordT   xmIr,
    input  cpuPkg::wordT   xmO,
    input  cpuPkg::wordT   xmB,
    input  cpuPkg::wordT   qDmem,
    input  logic           fwdStore,
    output cpuPkg::wordT   addressDmem,
    output cpuPkg::wordT   data,
    output logic           wren,
    output cpuPkg::wordT   mwIr,
    output logic           ctrlWriteEnable,
    output cpuPkg::regIdxT ctrlWriteReg,
    output cpuPkg::wordT   dataWriteReg,
    output cpuPkg::wordT   wbValue
);
    import cpuPkg::*;

    wordT mwO;      // ALU or mul result
    wordT mwD;      // Loaded word

    assign addressDmem = xmO;
    assign data        = fwdStore ? wbValue : xmB;    // lw then sw of the same reg
    assign wren        = opcodeOf(xmIr) == opSw;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            mwIr <= nopWord;
        end else begin
            mwIr <= xmIr;   // Never stalled, W keeps draining
        end
    end

    always_ff @(posedge clock) begin
        mwO <= xmO;
        mwD <= qDmem;
    end

    assign wbValue         = (opcodeOf(mwIr) == opLw) ? mwD : mwO;
    assign dataWriteReg    = wbValue;
    assign ctrlWriteEnable = writesReg(mwIr);      // Never r0, sw, branch or nop
    assign ctrlWriteReg    = rdOf(mwIr);

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
/*
 * hazardUnit
 * Bypass selects, load-use interlock and the stall and bubble controls
 */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  cpuPkg::wordT   fdIr,
    input  cpuPkg::wordT   dxIr,
    input  cpuPkg::wordT   xmIr,
    input  cpuPkg::wordT   mwIr,
    mulIf.monitor          mif,
    input  logic           mulPending,
    output logic           stallF,
    output logic           stallD,
    output logic           stallX,
    output logic           stallM,
    output logic           bubbleX,
    output cpuPkg::fwdSelT fwdA,
    output cpuPkg::fwdSelT fwdB,
    output logic           fwdStore
);
    import cpuPkg::*;

    logic xmFwd;        // X/M holds a result usable in X
    logic fdUsesB;
    logic loadUse;

    // Loaded data is not in X/M yet, only the address
    assign xmFwd = writesReg(xmIr) && opcodeOf(xmIr) != opLw;

    function automatic fwdSelT pickFwd(regIdxT src);
        if (xmFwd && rdOf(xmIr) == src) begin
            return fwdMem;
        end
        if (writesReg(mwIr) && rdOf(mwIr) == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        fwdA = pickFwd(rsOf(dxIr));
        fwdB = pickFwd(srcB(dxIr));
    end

    // sw data is left out, it gets the loaded word in M
    assign fdUsesB = opcodeOf(fdIr) inside {opAlu, opBne, opBlt};
    assign loadUse = opcodeOf(dxIr) == opLw && writesReg(dxIr) &&
                     ((opcodeOf(fdIr) != opJ && rsOf(fdIr) == rdOf(dxIr)) ||
                      (fdUsesB && srcB(fdIr) == rdOf(dxIr)));

    assign stallF  = loadUse || mulPending;
    assign stallD  = loadUse || mulPending;
    assign stallX  = mulPending;
    assign stallM  = mulPending && !mif.reqReady;  // First cycle lets M drain
    assign bubbleX = loadUse;

    assign fwdStore = opcodeOf(xmIr) == opSw && writesReg(mwIr) && rdOf(mwIr) == rdOf(xmIr);

endmodule

`default_nettype wire

// ==== rtl/executeStage.sv ====
/*
 * executeStage
 * D/X latch, operand bypass, immediate and ALU input select, branch
 * resolution, multiply request and the X/M latch
 */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic           clock,
    input  logic           rstN,
    input  cpuPkg::wordT   fdIr,
    input  cpuPkg::wordT   fdPc,
    input  cpuPkg::wordT   dataReadRegA,
    input  cpuPkg::wordT   dataReadRegB,
    input  logic           stallX,
    input  logic           stallM,
    input  logic           bubbleX,
    input  cpuPkg::fwdSelT fwdA,
    input  cpuPkg::fwdSelT fwdB,
    input  cpuPkg::wordT   wbValue,
    output cpuPkg::wordT   dxIr,
    output logic           branchTaken,
    output cpuPkg::wordT   branchTarget,
    output cpuPkg::wordT   xmIr,
    output cpuPkg::wordT   xmO,
    output cpuPkg::wordT   xmB,            // Store data
    output logic           mulPending,
    mulIf.requester        mif
);
    import cpuPkg::*;

    wordT   dxPc;
    wordT   dxA;
    wordT   dxB;
    wordT   opA;
    wordT   opB;
    wordT   imm;
    wordT   aluB;
    wordT   aluResult;
    opcodeT op;
    aluOpT  aluOp;
    logic   isImm;
    logic   isMul;
    logic   notEqual;
    logic   lessThan;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            dxIr <= nopWord;
        end else if (!stallX) begin
            dxIr <= (bubbleX || branchTaken) ? nopWord : fdIr;
        end
    end

    always_ff @(posedge clock) begin
        if (!stallX) begin
            dxPc <= fdPc;
            dxA  <= dataReadRegA;
            dxB  <= dataReadRegB;
        end
    end

    assign op    = opcodeOf(dxIr);
    assign imm   = {{15{dxIr[16]}}, dxIr[16:0]};     // 17-bit signed N
    assign isImm = op inside {opAddi, opLw, opSw};
    assign isMul = op == opAlu && dxIr[6:2] == aluMul;
    assign aluOp = (op == opAlu) ? dxIr[6:2] : aluAdd;

    // Nearer stage wins, decided in the hazard unit
    assign opA  = (fwdA == fwdMem) ? xmO : (fwdA == fwdWb) ? wbValue : dxA;
    assign opB  = (fwdB == fwdMem) ? xmO : (fwdB == fwdWb) ? wbValue : dxB;
    assign aluB = isImm ? imm : opB;

    alu uAlu (
        .a(opA), .b(aluB), .op(aluOp), .shamt(dxIr[11:7]),
        .result(aluResult), .notEqual, .lessThan
    );

    // a is $rs, b is $rd for the branches
    always_comb begin
        case (op)
            opJ:     branchTaken = 1'b1;
            opBne:   branchTaken = notEqual;
            opBlt:   branchTaken = notEqual && !lessThan;   // $rd < $rs
            default: branchTaken = 1'b0;
        endcase
    end

    assign branchTarget = (op == opJ) ? {5'b0, dxIr[26:0]} : dxPc + imm;

    // Request stays up until the result pulse
    assign mif.reqValid = isMul && !mif.resValid;
    assign mif.a        = opA;
    assign mif.b        = opB;
    assign mulPending   = mif.reqValid;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            xmIr <= nopWord;
        end else if (!stallM) begin
            xmIr <= mulPending ? nopWord : dxIr;    // Let M drain while waiting
        end
    end

    always_ff @(posedge clock) begin
        if (!stallM) begin
            xmO <= isMul ? mif.product : aluResult;
            xmB <= opB;
        end
    end

    // A new mul always finds the sequencer idle
    assert property (@(posedge clock) disable iff (!rstN)
        $rose(mif.reqValid) |-> mif.reqReady);

    // Result pulse lands while its mul is still held in X
    assert property (@(posedge clock) disable iff (!rstN) mif.resValid |-> isMul);

endmodule

`default_nettype wire

// ==== rtl/fetchDecode.sv ====
/*
 * fetchDecode
 * Program counter with next-PC select, the F/D latch and register read addresses
 */
`timescale 1ns/1ps
`default_nettype none

module fetchDecode (
    input  logic           clock,
    input  logic           rstN,
    input  cpuPkg::wordT   qImem,
    input  logic           stallF,
    input  logic           stallD,
    input  logic           branchTaken,
    input  cpuPkg::wordT   branchTarget,
    output cpuPkg::wordT   addressImem,
    output cpuPkg::wordT   fdIr,
    output cpuPkg::wordT   fdPc,           // PC+1 of the instruction in D
    output cpuPkg::regIdxT ctrlReadRegA,
    output cpuPkg::regIdxT ctrlReadRegB
);
    import cpuPkg::*;

    wordT pc;
    wordT pcPlusOne;

    assign pcPlusOne   = pc + 32'd1;
    assign addressImem = pc;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;         // Resolved in X
        end else if (!stallF) begin
            pc <= pcPlusOne;
        end
    end

    // Fetched word is squashed when X redirects
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            fdIr <= nopWord;
        end else if (branchTaken) begin
            fdIr <= nopWord;
        end else if (!stallD) begin
            fdIr <= qImem;
        end
    end

    always_ff @(posedge clock) begin
        if (!stallD) begin
            fdPc <= pcPlusOne;
        end
    end

    assign ctrlReadRegA = rsOf(fdIr);
    assign ctrlReadRegB = srcB(fdIr);  // rt, or rd for sw/bne/blt

    // Hazard stalls never coincide with a redirect, so a held fetch keeps its PC
    assert property (@(posedge clock) disable iff (!rstN) stallF |=> $stable(pc));

endmodule

`default_nettype wire

// ==== rtl/multiplier.sv ====
/*
 * multiplier
 * Shift-add datapath for the low word of a 32x32 product, one bit per step
 */
`timescale 1ns/1ps
`default_nettype none

module multiplier (
    input logic clock,
    input logic rstN,
    mulIf.unit  mif
);
    import cpuPkg::*;

    wordT mcand;        // Shifted left each step
    wordT mplier;       // Shifted right, low bit picks the add
    wordT acc;          // Partial product
    logic load;
    logic step;

    mulSequencer uSeq (
        .clock, .rstN, .reqValid(mif.reqValid),
        .reqReady(mif.reqReady), .load, .step, .resValid(mif.resValid)
    );

    always_ff @(posedge clock) begin
        if (load) begin
            mcand  <= mif.a;
            mplier <= mif.b;
            acc    <= '0;
        end else if (step) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign mif.product = acc;

endmodule

`default_nettype wire

// ==== rtl/mulSequencer.sv ====
/*
 * mulSequencer
 * Multiply FSM. Accepts a request when idle, runs mulSteps steps, then
 * pulses resValid for one cycle
 */
`timescale 1ns/1ps
`default_nettype none

module mulSequencer (
    input  logic clock,
    input  logic rstN,
    input  logic reqValid,
    output logic reqReady,
    output logic load,
    output logic step,
    output logic resValid
);
    import cpuPkg::*;

    localparam int cntW = $clog2(mulSteps);

    mulStateT        state;
    logic [cntW-1:0] count;     // Steps done so far

    assign reqReady = state == mulIdle;
    assign load     = reqReady && reqValid;    // Acceptance
    assign step     = state == mulRun;
    assign resValid = state == mulDone;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= mulIdle;
            count <= '0;
        end else begin
            case (state)
                mulIdle: begin
                    if (load) begin
                        state <= mulRun;
                        count <= '0;
                    end
                end
                mulRun: begin
                    count <= count + 1'b1;
                    if (count == cntW'(mulSteps - 1)) begin
                        state <= mulDone;   // Last step this cycle
                    end
                end
                default: state <= mulIdle;  // Done lasts one cycle
            endcase
        end
    end

    // Result pulse mulSteps+1 cycles after acceptance
    assert property (@(posedge clock) disable iff (!rstN) load |-> ##(mulSteps + 1) resValid);

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
/*
 * alu
 * Add, sub, and, or, sll and sra with signed not-equal and less-than flags
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    input  cpuPkg::aluOpT op,
    input  logic [4:0]    shamt,
    output cpuPkg::wordT  result,
    output logic          notEqual,
    output logic          lessThan
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSll:  result = a << shamt;
            aluSra:  result = wordT'($signed(a) >>> shamt);    // Sign fill
            default: result = '0;                              // mul goes elsewhere
        endcase
    end

    assign notEqual = a != b;
    assign lessThan = $signed(a) < $signed(b);

endmodule

`default_nettype wire

// ==== rtl/mulIf.sv ====
/*
 * mulIf
 * Multiply request and result between execute, the multiplier and the hazard unit
 */
`timescale 1ns/1ps
`default_nettype none

interface mulIf;
    import cpuPkg::*;

    logic reqValid;     // Mul waiting in X
    logic reqReady;     // Sequencer idle
    wordT a;            // Bypassed operands
    wordT b;
    wordT product;      // Low word of a*b
    logic resValid;     // One-cycle result pulse

    modport requester (output reqValid, a, b, input reqReady, product, resValid);
    modport unit      (input reqValid, a, b, output reqReady, product, resValid);
    modport monitor   (input reqValid, reqReady, a, b, product, resValid);

endinterface

`default_nettype wire

// ==== rtl/cpuPkg.sv ====
/*
 * cpuPkg
 * Word types, instruction encodings, bypass selects and field helpers
 * shared by every stage of the pipelined core
 */
`default_nettype none

package cpuPkg;

    typedef logic [31:0] wordT;     // Data word, instruction or address
    typedef logic [4:0]  regIdxT;   // Register index
    typedef logic [4:0]  opcodeT;   // Bits 31:27
    typedef logic [4:0]  aluOpT;    // Bits 6:2 of R-type
    typedef logic [1:0]  fwdSelT;   // Operand source in execute

    typedef enum logic [1:0] {
        mulIdle,
        mulRun,
        mulDone
    } mulStateT;

    localparam opcodeT opAlu  = 5'b00000;
    localparam opcodeT opJ    = 5'b00001;
    localparam opcodeT opBne  = 5'b00010;
    localparam opcodeT opAddi = 5'b00101;
    localparam opcodeT opBlt  = 5'b00110;
    localparam opcodeT opSw   = 5'b00111;
    localparam opcodeT opLw   = 5'b01000;

    localparam aluOpT aluAdd = 5'd0;
    localparam aluOpT aluSub = 5'd1;
    localparam aluOpT aluAnd = 5'd2;
    localparam aluOpT aluOr  = 5'd3;
    localparam aluOpT aluSll = 5'd4;
    localparam aluOpT aluSra = 5'd5;
    localparam aluOpT aluMul = 5'd6;

    localparam fwdSelT fwdReg = 2'd0;   // Value read in decode
    localparam fwdSelT fwdMem = 2'd1;   // Result sitting in X/M
    localparam fwdSelT fwdWb  = 2'd2;   // Value being written back

    localparam wordT nopWord  = '0;     // add r0, r0, r0
    localparam int   mulSteps = 32;

    function automatic opcodeT opcodeOf(wordT ir);
        return ir[31:27];
    endfunction

    function automatic regIdxT rdOf(wordT ir);
        return ir[26:22];
    endfunction

    function automatic regIdxT rsOf(wordT ir);
        return ir[21:17];
    endfunction

    // True when the instruction writes a register other than r0
    function automatic logic writesReg(wordT ir);
        return (opcodeOf(ir) inside {opAlu, opAddi, opLw}) && rdOf(ir) != '0;
    endfunction

    // Second source register, rd for sw and the branches
    function automatic regIdxT srcB(wordT ir);
        return (opcodeOf(ir) inside {opSw, opBne, opBlt}) ? rdOf(ir) : ir[16:12];
    endfunction

endpackage

`default_nettype wire
